/* flist.f */
+incdir+include
verilog/r5p_pkg.sv
verilog/r5p_dec.sv
verilog/r5p_gpr.sv
verilog/r5p_alu.sv
verilog/r5p_lsu.sv
verilog/r5p_core.sv
verification/r5p_mem_model.sv
verification/r5p_tb.sv

/* include/r5p_consts.svh */
`ifndef R5P_CONSTS_SVH
`define R5P_CONSTS_SVH

// register width
`define R5P_XW 32

// bus address width, shared by fetch and load/store
`define R5P_AW 32

// byte selects per data word
`define R5P_SW 4

// reset program counter
`define R5P_PC0 32'h0000_0000

// canonical nop, addi x0,x0,0
// also what the decoder sees in empty slots
`define R5P_NOP 32'h0000_0013

`endif

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module r5p_tb -o r5p_sim
./obj_dir/r5p_sim | tee sim.log

if grep -qx "CHECKS FAILED" sim.log; then
  exit 1
fi

/* verification/r5p_mem_model.sv */
`include "r5p_consts.svh"

module r5p_mem_model (
  input  logic               clk,
  // instruction side
  input  logic               if_req,
  input  logic [`R5P_AW-1:0] if_adr,
  output r5p_pkg::word_t     if_rdt,
  output logic               if_ack,
  // data side
  input  logic               ls_req,
  input  logic               ls_wen,
  input  logic [`R5P_AW-1:0] ls_adr,
  input  logic [`R5P_SW-1:0] ls_sel,
  input  r5p_pkg::word_t     ls_wdt,
  output r5p_pkg::word_t     ls_rdt,
  output logic               ls_ack
);
  timeunit 1ns;
  timeprecision 100ps;
  import r5p_pkg::*;

  // 256 words each
  // indexed by byte address bits 9:2
  word_t     rom [0:255];
  word_t     ram [0:255];
  logic      throttle;
  // every accepted write in order
  dbus_req_t wr_log [$];

  initial begin
    if_rdt   = `R5P_NOP;
    if_ack   = 1'b0;
    ls_ack   = 1'b0;
    throttle = 1'b0;
    // one seed for the whole run
    void'($urandom(32'hf7af_a1cf));
    // acks move shortly after each rising edge
    forever begin
      @(posedge clk);
      #2;
      // roughly 3 in 4 when throttled
      if (throttle) begin
        if_ack = ($urandom % 4) != 0;
        ls_ack = ($urandom % 4) != 0;
      end else begin
        if_ack = 1'b1;
        ls_ack = 1'b1;
      end
    end
  end

  // fetch word comes back the cycle after acceptance
  always @(posedge clk) begin
    if (if_req && if_ack) begin
      if_rdt <= rom[if_adr[9:2]];
    end
  end

  // read data is combinational from the address
  assign ls_rdt = ram[ls_adr[9:2]];

  // byte lane writes plus log entry
  always @(posedge clk) begin
    if (ls_req && ls_ack && ls_wen) begin
      for (int b = 0; b < `R5P_SW; b++) begin
        if (ls_sel[b]) begin
          ram[ls_adr[9:2]][8*b +: 8] = ls_wdt[8*b +: 8];
        end
      end
      wr_log.push_back({ls_adr, ls_sel, ls_wdt});
    end
  end

endmodule

/* verification/r5p_tb.sv */
`include "r5p_consts.svh"

module r5p_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import r5p_pkg::*;

  // 5 tests of ~40 instructions at a worst stall of ~8 plus margin
  localparam int MAX_CYCLES = 3000;

  logic               clk;
  logic               rst;
  logic               if_req;
  logic [`R5P_AW-1:0] if_adr;
  word_t              if_rdt;
  logic               if_ack;
  logic               ls_req;
  logic               ls_wen;
  logic [`R5P_AW-1:0] ls_adr;
  logic [`R5P_SW-1:0] ls_sel;
  word_t              ls_wdt;
  word_t              ls_rdt;
  logic               ls_ack;

  word_t     pgm [$];
  dbus_req_t exp_q [$];
  int        errors;
  int        checks;
  int        cycles;
  int        slot;

  r5p_core uut (
    .clk    (clk),
    .rst    (rst),
    .if_req (if_req),
    .if_adr (if_adr),
    .if_rdt (if_rdt),
    .if_ack (if_ack),
    .ls_req (ls_req),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_sel (ls_sel),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_ack (ls_ack)
  );

  r5p_mem_model mem (
    .clk    (clk),
    .if_req (if_req),
    .if_adr (if_adr),
    .if_rdt (if_rdt),
    .if_ack (if_ack),
    .ls_req (ls_req),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_sel (ls_sel),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_ack (ls_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests did not finish");
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // instruction assembly
  //////////////////////////////////////////////////////////////////////

  function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP};
  endfunction

  function automatic word_t enc_i(word_t imm, int rs1, int f3, int rd, opc_t opc);
    return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), opc};
  endfunction

  function automatic word_t enc_s(word_t imm, int rs2, int rs1, int f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], STORE};
  endfunction

  function automatic word_t enc_b(word_t imm, int rs1, int rs2, int f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic word_t enc_u(word_t imm, int rd, opc_t opc);
    return {imm[31:12], 5'(rd), opc};
  endfunction

  function automatic word_t enc_j(word_t imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), JAL};
  endfunction

  // byte address of the next instruction
  function automatic word_t cur_pc();
    return word_t'(pgm.size() * 4);
  endfunction

  task automatic expect_wr(word_t adr, logic [3:0] sel, word_t wdt);
    dbus_req_t r;
    r.adr = adr;
    r.sel = sel;
    r.wdt = wdt;
    exp_q.push_back(r);
  endtask

  // result in x4 goes to the next slot
  task automatic op_store(word_t ins, word_t val);
    pgm.push_back(ins);
    pgm.push_back(enc_s(word_t'(slot), 4, 0, 2));
    expect_wr(word_t'(slot), 4'hf, val);
    slot += 4;
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks and run control
  //////////////////////////////////////////////////////////////////////

  task automatic check_wr(dbus_req_t got, dbus_req_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t: %s got adr %h sel %h wdt %h, expected adr %h sel %h wdt %h",
               $time, what, got.adr, got.sel, got.wdt, exp.adr, exp.sel, exp.wdt);
    end
  endtask

  task automatic check_word(word_t got, word_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic start_test();
    pgm.delete();
    exp_q.delete();
    slot = 32'h100;
    for (int i = 0; i < 256; i++) begin
      mem.ram[i] = '0;
    end
  endtask

  task automatic run_prog(string name, bit thr);
    int    n;
    word_t park;
    // park in a self loop
    park = cur_pc();
    pgm.push_back(enc_j(0, 0));
    @(posedge clk);
    #2 rst = 1'b1;
    for (int i = 0; i < 256; i++) begin
      mem.rom[i] = (i < pgm.size()) ? pgm[i] : `R5P_NOP;
    end
    mem.wr_log.delete();
    mem.throttle = thr;
    repeat (4) @(posedge clk);
    #2 rst = 1'b0;
    while (mem.wr_log.size() < exp_q.size()) begin
      @(posedge clk);
    end
    // room for stray writes from a wrong path
    repeat (20) @(posedge clk);
    // fetch stays on the self loop once parked
    @(negedge clk);
    check_word(if_adr, park, {name, " parked fetch address"});
    n = exp_q.size();
    if (mem.wr_log.size() != n) begin
      errors++;
      $display("%s: wrong number of data writes, %0d logged and %0d expected",
               name, mem.wr_log.size(), n);
      if (mem.wr_log.size() < n) begin
        n = mem.wr_log.size();
      end
    end
    for (int i = 0; i < n; i++) begin
      check_wr(mem.wr_log[i], exp_q[i], name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic alu_test(bit thr);
    word_t a;
    word_t b;
    word_t c;
    a = 32'h8765_4321;
    b = 32'hffff_fffb;
    c = 32'd7;
    start_test();
    pgm.push_back(enc_u(32'h8765_4000, 1, LUI));
    pgm.push_back(enc_i(32'h321, 1, 0, 1, OP_IMM));
    pgm.push_back(enc_i(32'hffff_fffb, 0, 0, 2, OP_IMM));
    pgm.push_back(enc_i(32'd7, 0, 0, 3, OP_IMM));
    // register forms
    op_store(enc_r(0, 2, 1, 0, 4), a + b);
    op_store(enc_r(32, 2, 1, 0, 4), a - b);
    op_store(enc_r(0, 3, 1, 1, 4), a << c[4:0]);
    // mixed signs so signed and unsigned compares differ
    op_store(enc_r(0, 3, 1, 2, 4), word_t'($signed(a) < $signed(c)));
    op_store(enc_r(0, 3, 1, 3, 4), word_t'(a < c));
    op_store(enc_r(0, 2, 1, 4, 4), a ^ b);
    op_store(enc_r(0, 3, 1, 5, 4), a >> c[4:0]);
    op_store(enc_r(32, 3, 1, 5, 4), word_t'($signed(a) >>> c[4:0]));
    op_store(enc_r(0, 2, 1, 6, 4), a | b);
    op_store(enc_r(0, 2, 1, 7, 4), a & b);
    // immediate forms
    op_store(enc_i(32'hffff_ff9c, 1, 0, 4, OP_IMM), a - 32'd100);
    op_store(enc_i(32'hffff_fffc, 3, 2, 4, OP_IMM), word_t'($signed(c) < -4));
    op_store(enc_i(32'hffff_ffff, 3, 3, 4, OP_IMM), word_t'(c < 32'hffff_ffff));
    op_store(enc_i(32'h7ff, 1, 4, 4, OP_IMM), a ^ 32'h7ff);
    op_store(enc_i(32'hffff_ff00, 1, 6, 4, OP_IMM), a | 32'hffff_ff00);
    op_store(enc_i(32'h0f0, 1, 7, 4, OP_IMM), a & 32'h0f0);
    op_store(enc_i(32'd4, 1, 1, 4, OP_IMM), a << 4);
    op_store(enc_i(32'd9, 1, 5, 4, OP_IMM), a >> 9);
    // bit 10 of the immediate selects srai
    op_store(enc_i(32'h409, 1, 5, 4, OP_IMM), word_t'($signed(a) >>> 9));
    op_store(enc_u(32'h1234_5000, 4, AUIPC), cur_pc() + 32'h1234_5000);
    run_prog(thr ? "alu throttled" : "alu", thr);
  endtask

  task automatic store_test();
    word_t v;
    v = 32'ha1b2_c3d4;
    start_test();
    pgm.push_back(enc_u(32'ha1b2_c000, 5, LUI));
    pgm.push_back(enc_i(32'h3d4, 5, 0, 5, OP_IMM));
    // sb at every offset
    for (int o = 0; o < 4; o++) begin
      pgm.push_back(enc_s(word_t'(32'h200 + o), 5, 0, 0));
      expect_wr(32'h200, 4'(4'b0001 << o), (v & 32'hff) << (8 * o));
    end
    // sh at both halves
    for (int o = 0; o < 4; o += 2) begin
      pgm.push_back(enc_s(word_t'(32'h204 + o), 5, 0, 1));
      expect_wr(32'h204, 4'(4'b0011 << o), (v & 32'hffff) << (8 * o));
    end
    pgm.push_back(enc_s(32'h208, 5, 0, 2));
    expect_wr(32'h208, 4'hf, v);
    run_prog("store", 1'b0);
    check_word(mem.ram[32'h200 >> 2], {4{v[7:0]}}, "sb lanes in ram");
    check_word(mem.ram[32'h204 >> 2], {2{v[15:0]}}, "sh lanes in ram");
    check_word(mem.ram[32'h208 >> 2], v, "sw in ram");
  endtask

  task automatic load_test();
    word_t      w;
    logic [7:0] bv;
    logic [15:0] hv;
    w = 32'h8091_f0a5;
    start_test();
    mem.ram[32'h300 >> 2] = w;
    // every byte and half has its top bit set
    for (int o = 0; o < 4; o++) begin
      bv = w[8*o +: 8];
      op_store(enc_i(word_t'(32'h300 + o), 0, 0, 4, LOAD), {{24{bv[7]}}, bv});
      op_store(enc_i(word_t'(32'h300 + o), 0, 4, 4, LOAD), {24'h0, bv});
    end
    for (int o = 0; o < 4; o += 2) begin
      hv = w[8*o +: 16];
      op_store(enc_i(word_t'(32'h300 + o), 0, 1, 4, LOAD), {{16{hv[15]}}, hv});
      op_store(enc_i(word_t'(32'h300 + o), 0, 5, 4, LOAD), {16'h0, hv});
    end
    op_store(enc_i(32'h300, 0, 2, 4, LOAD), w);
    run_prog("load", 1'b0);
  endtask

  // RV32I branch conditions by funct3
  function automatic bit branch_taken(int f3, word_t x, word_t y);
    case (f3)
      0:       return x == y;
      1:       return x != y;
      4:       return $signed(x) < $signed(y);
      5:       return $signed(x) >= $signed(y);
      6:       return x < y;
      default: return x >= y;
    endcase
  endfunction

  // branch over a marker store
  // x8 marks the fall through and x9 the join
  task automatic branch_case(int f3, int r1, int r2);
    word_t v1;
    word_t v2;
    v1 = (r1 == 1) ? 32'd5 : 32'hffff_fffd;
    v2 = (r2 == 1) ? 32'd5 : 32'hffff_fffd;
    pgm.push_back(enc_b(32'd8, r1, r2, f3));
    pgm.push_back(enc_s(word_t'(slot), 8, 0, 2));
    pgm.push_back(enc_s(word_t'(slot + 4), 9, 0, 2));
    if (!branch_taken(f3, v1, v2)) begin
      expect_wr(word_t'(slot), 4'hf, 32'h11);
    end
    expect_wr(word_t'(slot + 4), 4'hf, 32'h22);
    slot += 8;
  endtask

  task automatic ctrl_test(bit thr);
    word_t p;
    start_test();
    pgm.push_back(enc_i(32'd5, 0, 0, 1, OP_IMM));
    pgm.push_back(enc_i(32'hffff_fffd, 0, 0, 2, OP_IMM));
    pgm.push_back(enc_i(32'h11, 0, 0, 8, OP_IMM));
    pgm.push_back(enc_i(32'h22, 0, 0, 9, OP_IMM));
    // taken and untaken for each condition
    for (int f3 = 0; f3 < 8; f3++) begin
      if (f3 != 2 && f3 != 3) begin
        branch_case(f3, 1, 2);
        branch_case(f3, 2, 1);
      end
    end
    // equal operands for the other outcome of beq and bne
    branch_case(0, 1, 1);
    branch_case(1, 1, 1);
    // jal over the marker with its link stored
    p = cur_pc();
    pgm.push_back(enc_j(32'd8, 11));
    pgm.push_back(enc_s(word_t'(slot), 8, 0, 2));
    pgm.push_back(enc_s(word_t'(slot + 4), 11, 0, 2));
    expect_wr(word_t'(slot + 4), 4'hf, p + 4);
    slot += 8;
    // jalr to a computed target
    p = cur_pc();
    pgm.push_back(enc_i(p + 12, 0, 0, 12, OP_IMM));
    pgm.push_back(enc_i(32'd0, 12, 0, 13, JALR));
    pgm.push_back(enc_s(word_t'(slot), 8, 0, 2));
    pgm.push_back(enc_s(word_t'(slot + 4), 13, 0, 2));
    expect_wr(word_t'(slot + 4), 4'hf, p + 8);
    slot += 8;
    run_prog(thr ? "control throttled" : "control", thr);
  endtask

  task automatic x0_test();
    start_test();
    pgm.push_back(enc_i(32'd9, 0, 0, 1, OP_IMM));
    pgm.push_back(enc_i(32'd55, 0, 0, 0, OP_IMM));
    pgm.push_back(enc_r(0, 1, 1, 0, 0));
    pgm.push_back(enc_u(32'hfffff000, 0, LUI));
    pgm.push_back(enc_s(word_t'(slot), 0, 0, 2));
    expect_wr(word_t'(slot), 4'hf, 32'd0);
    slot += 4;
    // x0 as an operand still reads zero
    op_store(enc_r(0, 1, 0, 0, 4), 32'd9);
    run_prog("x0", 1'b0);
  endtask

  initial begin
    rst      = 1'b1;
    errors   = 0;
    checks   = 0;
    cycles   = 0;
    alu_test(1'b0);
    store_test();
    load_test();
    ctrl_test(1'b0);
    x0_test();
    // same programs under random back-pressure
    alu_test(1'b1);
    ctrl_test(1'b1);
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* verilog/r5p_alu.sv */
`include "r5p_consts.svh"

module r5p_alu (
  input  r5p_pkg::alu_op_t op,
  input  r5p_pkg::br_op_t  br,
  input  r5p_pkg::word_t   rs1,
  input  r5p_pkg::word_t   rs2,
  input  r5p_pkg::word_t   br_rs1,
  input  r5p_pkg::word_t   br_rs2,
  output r5p_pkg::word_t   rd,
  output r5p_pkg::word_t   sum,
  output logic             tkn
);
  import r5p_pkg::*;

  localparam int unsigned SHW = $clog2(`R5P_XW);

  logic [SHW-1:0] sha;
  logic           eq;
  logic           lt;
  logic           ltu;

  // adder always live, used for jump and memory addresses
  assign sum = rs1 + rs2;
  // shift amount from low operand bits
  assign sha = rs2[SHW-1:0];

  always_comb begin
    case (op)
      SUB:     rd = rs1 - rs2;
      SLL:     rd = rs1 << sha;
      SLT:     rd = word_t'($signed(rs1) < $signed(rs2));
      SLTU:    rd = word_t'(rs1 < rs2);
      XOR:     rd = rs1 ^ rs2;
      SRL:     rd = rs1 >> sha;
      SRA:     rd = word_t'($signed(rs1) >>> sha);
      OR:      rd = rs1 | rs2;
      AND:     rd = rs1 & rs2;
      default: rd = sum;
    endcase
  end

  // branch comparator on the raw register values
  assign eq  = (br_rs1 == br_rs2);
  assign lt  = ($signed(br_rs1) < $signed(br_rs2));
  assign ltu = (br_rs1 < br_rs2);

  always_comb begin
    case (br)
      EQ:      tkn = eq;
      NE:      tkn = ~eq;
      LT:      tkn = lt;
      GE:      tkn = ~lt;
      LTU:     tkn = ltu;
      GEU:     tkn = ~ltu;
      JUMP:    tkn = 1'b1;
      default: tkn = 1'b0;
    endcase
  end

endmodule

/* verilog/r5p_core.sv */
`include "r5p_consts.svh"

module r5p_core (
  input  logic               clk,
  input  logic               rst,
  // instruction fetch bus
  output logic               if_req,
  output logic [`R5P_AW-1:0] if_adr,
  input  r5p_pkg::word_t     if_rdt,
  input  logic               if_ack,
  // load/store bus
  output logic               ls_req,
  output logic               ls_wen,
  output logic [`R5P_AW-1:0] ls_adr,
  output logic [`R5P_SW-1:0] ls_sel,
  output r5p_pkg::word_t     ls_wdt,
  input  r5p_pkg::word_t     ls_rdt,
  input  logic               ls_ack
);
  import r5p_pkg::*;

  // fetch / pc
  logic [`R5P_AW-1:0] pc;
  logic [`R5P_AW-1:0] pca;
  logic [`R5P_AW-1:0] pcn;
  logic               id_vld;
  logic               stall;
  // decode
  ctl_t               ctl;
  // register file
  word_t              gpr_rs1;
  word_t              gpr_rs2;
  word_t              gpr_rd;
  logic               gpr_we;
  // alu
  word_t              alu_rs1;
  word_t              alu_rs2;
  word_t              alu_rd;
  word_t              alu_sum;
  logic               alu_tkn;
  // load/store
  dbus_req_t          dreq;
  word_t              ld_rdt;

  //////////////////////////////////////////////////////////////////////
  // fetch and program counter
  //////////////////////////////////////////////////////////////////////

  // fetch starts one cycle after reset, never drops
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      if_req <= 1'b0;
      id_vld <= 1'b0;
    end else begin
      if_req <= 1'b1;
      // word arrives the cycle after an accepted request
      id_vld <= if_req & if_ack;
    end
  end

  // either bus holding off freezes everything
  assign stall = ~if_ack | (ls_req & ~ls_ack);

  assign pca = pc + `R5P_AW'(4);

  // next pc doubles as fetch address
  // while stalled the current word is fetched again
  always_comb begin
    if (id_vld && !stall) begin
      pcn = alu_tkn ? {alu_sum[`R5P_AW-1:1], 1'b0} : pca;
    end else begin
      pcn = pc;
    end
  end

  assign if_adr = pcn;

  // pc tracks the instruction in execute
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc <= `R5P_AW'(`R5P_PC0);
    end else if (id_vld && !stall) begin
      pc <= pcn;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // decode and execute
  //////////////////////////////////////////////////////////////////////

  r5p_dec dec (
    .op  (if_rdt),
    .vld (id_vld),
    .ctl (ctl)
  );

  // retire only on a completed cycle
  assign gpr_we = ctl.gpr.we & id_vld & ~stall;

  r5p_gpr gpr (
    .clk   (clk),
    .rst   (rst),
    .ctl   (ctl.gpr),
    .we    (gpr_we),
    .d_rd  (gpr_rd),
    .d_rs1 (gpr_rs1),
    .d_rs2 (gpr_rs2)
  );

  // operand muxes
  always_comb begin
    case (ctl.a1)
      A1_PC:   alu_rs1 = `R5P_XW'(pc);
      A1_ZERO: alu_rs1 = '0;
      default: alu_rs1 = gpr_rs1;
    endcase
    alu_rs2 = (ctl.a2 == A2_IMM) ? ctl.imm : gpr_rs2;
  end

  r5p_alu alu (
    .op     (ctl.alu),
    .br     (ctl.br),
    .rs1    (alu_rs1),
    .rs2    (alu_rs2),
    .br_rs1 (gpr_rs1),
    .br_rs2 (gpr_rs2),
    .rd     (alu_rd),
    .sum    (alu_sum),
    .tkn    (alu_tkn)
  );

  //////////////////////////////////////////////////////////////////////
  // load/store and write back
  //////////////////////////////////////////////////////////////////////

  r5p_lsu lsu (
    .ctl     (ctl.ls),
    .adr     (alu_sum),
    .wdt_in  (gpr_rs2),
    .rdt     (ls_rdt),
    .req     (dreq),
    .rdt_ext (ld_rdt)
  );

  // Held back while the fetch is stalled, so a store is issued
  // exactly once per retired instruction.
  assign ls_req = ctl.ls.en & if_ack;
  assign ls_wen = ctl.ls.we;
  assign ls_adr = dreq.adr;
  assign ls_sel = dreq.sel;
  assign ls_wdt = dreq.wdt;

  // write back source, link value is pc+4
  always_comb begin
    case (ctl.wb)
      WB_ALU:  gpr_rd = alu_rd;
      WB_MEM:  gpr_rd = ld_rdt;
      WB_PCN:  gpr_rd = `R5P_XW'(pca);
      default: gpr_rd = '0;
    endcase
  end

endmodule

/* verilog/r5p_dec.sv */
`include "r5p_consts.svh"

module r5p_dec (
  input  r5p_pkg::word_t op,
  input  logic           vld,
  output r5p_pkg::ctl_t  ctl
);
  import r5p_pkg::*;

  word_t      ins;
  opc_t       opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       rd_nz;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // funct3 to alu op, alt selects sub / arithmetic shift
  function automatic alu_op_t alu_sel(input logic [2:0] fn, input logic alt);
    case (fn)
      3'b000:  alu_sel = alt ? SUB : ADD;
      3'b001:  alu_sel = SLL;
      3'b010:  alu_sel = SLT;
      3'b011:  alu_sel = SLTU;
      3'b100:  alu_sel = XOR;
      3'b101:  alu_sel = alt ? SRA : SRL;
      3'b110:  alu_sel = OR;
      default: alu_sel = AND;
    endcase
  endfunction

  // empty slots decode as the nop
  assign ins   = vld ? op : `R5P_NOP;
  assign opc   = opc_t'(ins[6:0]);
  assign f3    = ins[14:12];
  assign f7    = ins[31:25];
  // writes to x0 never enable the port
  assign rd_nz = (ins[11:7] != 5'd0);

  // immediates
  assign imm_i = {{20{ins[31]}}, ins[31:20]};
  assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign imm_u = {ins[31:12], 12'h000};
  assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

  always_comb begin
    // inactive defaults: no write, no bus access, no branch
    ctl         = '0;
    ctl.gpr.rs1 = ins[19:15];
    ctl.gpr.rs2 = ins[24:20];
    ctl.gpr.rd  = ins[11:7];
    case (opc)
      LUI, AUIPC: begin
        ctl.gpr.we = rd_nz;
        ctl.a1     = (opc == LUI) ? A1_ZERO : A1_PC;
        ctl.a2     = A2_IMM;
        ctl.wb     = WB_ALU;
        ctl.imm    = imm_u;
      end
      JAL, JALR: begin
        // jalr target is rs1 based, jal is pc relative
        ctl.gpr.we = rd_nz;
        ctl.a1     = (opc == JAL) ? A1_PC : A1_RS1;
        ctl.a2     = A2_IMM;
        ctl.br     = JUMP;
        ctl.wb     = WB_PCN;
        ctl.imm    = (opc == JAL) ? imm_j : imm_i;
      end
      BRANCH: begin
        ctl.a1  = A1_PC;
        ctl.a2  = A2_IMM;
        ctl.imm = imm_b;
        case (f3)
          3'b000:  ctl.br = EQ;
          3'b001:  ctl.br = NE;
          3'b100:  ctl.br = LT;
          3'b101:  ctl.br = GE;
          3'b110:  ctl.br = LTU;
          3'b111:  ctl.br = GEU;
          default: ctl.br = NONE;
        endcase
      end
      LOAD: begin
        // legal: lb lh lw lbu lhu
        if (f3[1:0] != 2'b11 && f3[2:1] != 2'b11) begin
          ctl.gpr.we  = rd_nz;
          ctl.a2      = A2_IMM;
          ctl.imm     = imm_i;
          ctl.ls.en   = 1'b1;
          ctl.ls.size = ls_sz_t'(f3[1:0]);
          ctl.ls.sign = ~f3[2];
          ctl.wb      = WB_MEM;
        end
      end
      STORE: begin
        if (!f3[2] && f3[1:0] != 2'b11) begin
          ctl.a2      = A2_IMM;
          ctl.imm     = imm_s;
          ctl.ls.en   = 1'b1;
          ctl.ls.we   = 1'b1;
          ctl.ls.size = ls_sz_t'(f3[1:0]);
        end
      end
      OP_IMM: begin
        // bit 30 only matters for srai
        ctl.gpr.we = rd_nz;
        ctl.a2     = A2_IMM;
        ctl.alu    = alu_sel(f3, f7[5] & (f3 == 3'b101));
        ctl.wb     = WB_ALU;
        ctl.imm    = imm_i;
      end
      OP: begin
        ctl.gpr.we = rd_nz;
        ctl.alu    = alu_sel(f3, f7[5]);
        ctl.wb     = WB_ALU;
      end
      // fence, system and unknown opcodes stay inactive
      default: ;
    endcase
  end

endmodule

/* verilog/r5p_gpr.sv */
`include "r5p_consts.svh"

module r5p_gpr (
  input  logic              clk,
  input  logic              rst,
  input  r5p_pkg::gpr_ctl_t ctl,
  input  logic              we,
  input  r5p_pkg::word_t    d_rd,
  output r5p_pkg::word_t    d_rs1,
  output r5p_pkg::word_t    d_rs2
);
  import r5p_pkg::*;

  // x1..x31 only, x0 has no storage
  word_t gpr [1:31];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        gpr[i] <= '0;
      end
    end else if (we && ctl.rd != 5'd0) begin
      gpr[ctl.rd] <= d_rd;
    end
  end

  // asynchronous read ports, x0 reads zero
  assign d_rs1 = (ctl.rs1 == 5'd0) ? '0 : gpr[ctl.rs1];
  assign d_rs2 = (ctl.rs2 == 5'd0) ? '0 : gpr[ctl.rs2];

endmodule

/* verilog/r5p_lsu.sv */
`include "r5p_consts.svh"

module r5p_lsu (
  input  r5p_pkg::ls_ctl_t   ctl,
  input  r5p_pkg::word_t     adr,
  input  r5p_pkg::word_t     wdt_in,
  input  r5p_pkg::word_t     rdt,
  output r5p_pkg::dbus_req_t req,
  output r5p_pkg::word_t     rdt_ext
);
  import r5p_pkg::*;

  // byte offset width within a word
  localparam int unsigned OFW = $clog2(`R5P_SW);

  logic [OFW-1:0] off;
  logic [OFW+2:0] bsh;
  word_t          rsh;
  logic           fill;

  assign off = adr[OFW-1:0];
  // offset in bits
  assign bsh = {off, 3'b000};

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    req.adr = {adr[`R5P_AW-1:OFW], OFW'(0)};
    // misaligned accesses just shift, lanes past the word drop out
    case (ctl.size)
      SZ_B: begin
        req.sel = `R5P_SW'(4'b0001) << off;
        req.wdt = (wdt_in & word_t'(8'hff)) << bsh;
      end
      SZ_H: begin
        req.sel = `R5P_SW'(4'b0011) << off;
        req.wdt = (wdt_in & word_t'(16'hffff)) << bsh;
      end
      default: begin
        req.sel = `R5P_SW'(4'b1111) << off;
        req.wdt = wdt_in << bsh;
      end
    endcase
    // quiet selects when no access
    if (!ctl.en) begin
      req.sel = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // load extraction
  //////////////////////////////////////////////////////////////////////

  // move the addressed lane down to bit 0
  assign rsh = rdt >> bsh;

  always_comb begin
    case (ctl.size)
      SZ_B: begin
        fill    = ctl.sign & rsh[7];
        rdt_ext = {{(`R5P_XW-8){fill}}, rsh[7:0]};
      end
      SZ_H: begin
        fill    = ctl.sign & rsh[15];
        rdt_ext = {{(`R5P_XW-16){fill}}, rsh[15:0]};
      end
      default: begin
        fill    = 1'b0;
        rdt_ext = rsh;
      end
    endcase
  end

endmodule

/* verilog/r5p_pkg.sv */
`include "r5p_consts.svh"

package r5p_pkg;

  // one register / data bus word
  typedef logic [`R5P_XW-1:0] word_t;

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // major opcodes, ins[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opc_t;

  // alu operations
  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  // branch conditions, JUMP is unconditional
  typedef enum logic [2:0] {
    NONE, EQ, NE, LT, GE, LTU, GEU, JUMP
  } br_op_t;

  // load/store transfer size
  typedef enum logic [1:0] {SZ_B, SZ_H, SZ_W} ls_sz_t;

  // alu operand sources
  typedef enum logic [1:0] {A1_RS1, A1_PC, A1_ZERO} a1_t;
  typedef enum logic {A2_RS2, A2_IMM} a2_t;

  // write back source
  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PCN} wb_t;

  //////////////////////////////////////////////////////////////////////
  // control and bus structs
  //////////////////////////////////////////////////////////////////////

  // register file addressing
  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic       we;
  } gpr_ctl_t;

  // load/store control
  typedef struct packed {
    logic   en;
    logic   we;
    ls_sz_t size;
    // sign extend on load
    logic   sign;
  } ls_ctl_t;

  // full decoded instruction
  typedef struct packed {
    gpr_ctl_t gpr;
    a1_t      a1;
    a2_t      a2;
    alu_op_t  alu;
    br_op_t   br;
    ls_ctl_t  ls;
    wb_t      wb;
    word_t    imm;
  } ctl_t;

  // formatted data bus request
  typedef struct packed {
    logic [`R5P_AW-1:0] adr;
    logic [`R5P_SW-1:0] sel;
    word_t              wdt;
  } dbus_req_t;

endpackage
